// ==== flist.f ====
verilog/tlc_pkg.sv
verilog/tlc_decode.sv
verilog/tlc_miss_handler.sv
verilog/tlc_tag_lookup.sv
verilog/tlc_result.sv
verilog/tlc_top.sv
test/tlc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only if the pass message shows up.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tlc_tb \
  -f flist.f --Mdir obj_dir -o tlc_sim || exit 1
out=$(./obj_dir/tlc_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***' && echo "run.sh: pass" ||
  { echo "run.sh: fail"; exit 1; }

// ==== test/tlc_stim.txt ====
// cmd id addr data credit_delay, all hex, credit_delay counts cycles
// cmd 0 load, 1 store, 2 invalidate, 3 reserved, f marks the end of the list
0 1 011 0000 0
0 2 011 0000 0
1 3 011 abcd 0
0 4 011 0000 0
1 5 105 1234 0
0 6 105 0000 0
0 7 002 0000 0
0 8 012 0000 0
0 9 022 0000 0
0 a 012 0000 0
0 b 002 0000 0
2 c 001 0000 0
0 d 011 0000 0
3 e 7ff 5555 0
0 f 105 0000 14
1 0 022 0f0f 1e
0 1 022 0000 0
0 2 3ff 0000 28
2 3 003 0000 0
0 4 3ff 0000 3
f 0 000 0000 0

// ==== test/tlc_tb.sv ====
// testbench for the tag-lookup cache
// requester, memory model and cache model driven from the stimulus file
`timescale 1ns/1ns
`default_nettype none

module tlc_tb;

  localparam int addr_width_lp      = tlc_pkg::ADDR_WIDTH;
  localparam int data_width_lp      = tlc_pkg::DATA_WIDTH;
  localparam int id_width_lp        = tlc_pkg::ID_WIDTH;
  localparam int ways_lp            = tlc_pkg::WAYS;
  localparam int sets_lp            = tlc_pkg::SETS;
  localparam int credits_lp         = tlc_pkg::CREDITS;
  localparam int lg_sets_lp         = $clog2(sets_lp);
  localparam int tag_width_lp       = addr_width_lp - lg_sets_lp;
  localparam int max_lines_lp       = 64;
  localparam int cycles_per_line_lp = 200;

  logic                     clk_i;
  logic                     reset_i;
  logic                     req_v_i;
  tlc_pkg::tlc_cmd_e        req_cmd_i;
  logic [id_width_lp-1:0]   req_id_i;
  logic [addr_width_lp-1:0] req_addr_i;
  logic [data_width_lp-1:0] req_data_i;
  logic                     req_credit_o;
  logic                     resp_v_o;
  logic [id_width_lp-1:0]   resp_id_o;
  logic [data_width_lp-1:0] resp_data_o;
  logic                     resp_hit_o;
  tlc_pkg::tlc_status_e     resp_status_o;
  logic                     resp_credit_i;
  logic                     mem_req_v_o;
  logic                     mem_req_we_o;
  logic [addr_width_lp-1:0] mem_req_addr_o;
  logic [data_width_lp-1:0] mem_req_data_o;
  logic                     mem_req_ready_i;
  logic                     mem_resp_v_i;
  logic [data_width_lp-1:0] mem_resp_data_i;

  // each request takes five words in the order of the stimulus file
  logic [data_width_lp-1:0] stim_mem [5*max_lines_lp];

  // memory as the DUT sees it, and the reference memory for expected data
  logic [data_width_lp-1:0] mem_model [logic [addr_width_lp-1:0]];
  logic [data_width_lp-1:0] ref_mem   [logic [addr_width_lp-1:0]];

  logic                     model_valid [sets_lp][ways_lp];
  logic [tag_width_lp-1:0]  model_tag   [sets_lp][ways_lp];
  int                       model_rr    [sets_lp];

  logic [id_width_lp-1:0]   exp_id_q   [$];
  logic [data_width_lp-1:0] exp_data_q [$];
  logic                     exp_hit_q  [$];
  tlc_pkg::tlc_status_e     exp_stat_q [$];
  int                       exp_delay_q [$];
  int                       credit_due_q [$];

  int                       num_lines;
  int                       line_idx;
  int                       resp_count;
  int                       req_credits;
  int                       cycle_count;
  int                       cycle_limit;
  int                       rd_countdown;
  logic                     rd_pending;
  logic [data_width_lp-1:0] rd_data;

  tlc_top #(
    .addr_width_p(addr_width_lp),
    .data_width_p(data_width_lp),
    .id_width_p  (id_width_lp),
    .ways_p      (ways_lp),
    .sets_p      (sets_lp),
    .credits_p   (credits_lp)
  ) u_dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_v_i        (req_v_i),
    .req_cmd_i      (req_cmd_i),
    .req_id_i       (req_id_i),
    .req_addr_i     (req_addr_i),
    .req_data_i     (req_data_i),
    .req_credit_o   (req_credit_o),
    .resp_v_o       (resp_v_o),
    .resp_id_o      (resp_id_o),
    .resp_data_o    (resp_data_o),
    .resp_hit_o     (resp_hit_o),
    .resp_status_o  (resp_status_o),
    .resp_credit_i  (resp_credit_i),
    .mem_req_v_o    (mem_req_v_o),
    .mem_req_we_o   (mem_req_we_o),
    .mem_req_addr_o (mem_req_addr_o),
    .mem_req_data_o (mem_req_data_o),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_resp_v_i   (mem_resp_v_i),
    .mem_resp_data_i(mem_resp_data_i)
  );

  always #10 clk_i = ~clk_i;

  task automatic stop_on_error();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
      stop_on_error();
    end
  endtask

  // memory contents before any write depend on the whole address
  function automatic logic [data_width_lp-1:0] init_word(
      input logic [addr_width_lp-1:0] addr);
    logic [31:0] product;
    product = 32'(addr) * 32'd257;
    return product[data_width_lp-1:0];
  endfunction

  function automatic logic [data_width_lp-1:0] mem_read(input logic [addr_width_lp-1:0] addr);
    if (mem_model.exists(addr)) begin
      return mem_model[addr];
    end
    return init_word(addr);
  endfunction

  function automatic logic [data_width_lp-1:0] ref_read(input logic [addr_width_lp-1:0] addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return init_word(addr);
  endfunction

  // requests are handled strictly in order, so the models advance at issue time
  task automatic predict_response(input tlc_pkg::tlc_cmd_e cmd,
                                  input logic [id_width_lp-1:0] id,
                                  input logic [addr_width_lp-1:0] addr,
                                  input logic [data_width_lp-1:0] data,
                                  input int delay);
    int                       set;
    logic [tag_width_lp-1:0]  tag;
    logic                     hit;
    logic [data_width_lp-1:0] exp_data;
    tlc_pkg::tlc_status_e     exp_stat;
    set      = int'(addr[lg_sets_lp-1:0]);
    tag      = addr[addr_width_lp-1:lg_sets_lp];
    hit      = 1'b0;
    exp_data = '0;
    exp_stat = tlc_pkg::STAT_OK;
    for (int w = 0; w < ways_lp; w++) begin
      if (model_valid[set][w] && model_tag[set][w] == tag) begin
        hit = 1'b1;
      end
    end
    case (cmd)
      tlc_pkg::CMD_LOAD: begin
        exp_data = ref_read(addr);
        if (!hit) begin
          model_tag[set][model_rr[set]]   = tag;
          model_valid[set][model_rr[set]] = 1'b1;
          model_rr[set] = (model_rr[set] + 1) % ways_lp;
        end
      end
      tlc_pkg::CMD_STORE: begin
        ref_mem[addr] = data;
        exp_data = data;
      end
      tlc_pkg::CMD_INVAL: begin
        for (int w = 0; w < ways_lp; w++) begin
          model_valid[set][w] = 1'b0;
        end
        hit = 1'b0;
      end
      default: begin
        exp_stat = tlc_pkg::STAT_ERR;
        hit      = 1'b0;
      end
    endcase
    exp_id_q.push_back(id);
    exp_data_q.push_back(exp_data);
    exp_hit_q.push_back(hit);
    exp_stat_q.push_back(exp_stat);
    exp_delay_q.push_back(delay);
  endtask

  task automatic drive_memory();
    mem_resp_v_i = 1'b0;
    if (rd_pending) begin
      rd_countdown--;
      if (rd_countdown == 0) begin
        mem_resp_v_i    = 1'b1;
        mem_resp_data_i = rd_data;
        rd_pending      = 1'b0;
      end
    end
  endtask

  // only one credit goes back per cycle and the rest wait their turn
  task automatic drive_resp_credit();
    int due_idx;
    due_idx = -1;
    foreach (credit_due_q[i]) begin
      if (due_idx < 0 && credit_due_q[i] <= cycle_count) begin
        due_idx = i;
      end
    end
    resp_credit_i = (due_idx >= 0);
    if (due_idx >= 0) begin
      credit_due_q.delete(due_idx);
    end
  endtask

  task automatic drive_request();
    int base;
    base = 5 * line_idx;
    if (line_idx < num_lines && req_credits > 0) begin
      req_v_i    = 1'b1;
      req_cmd_i  = tlc_pkg::tlc_cmd_e'(stim_mem[base][1:0]);
      req_id_i   = stim_mem[base + 1][id_width_lp-1:0];
      req_addr_i = stim_mem[base + 2][addr_width_lp-1:0];
      req_data_i = stim_mem[base + 3];
      predict_response(req_cmd_i, req_id_i, req_addr_i, req_data_i, int'(stim_mem[base + 4]));
      req_credits--;
      line_idx++;
    end else begin
      req_v_i = 1'b0;
    end
  endtask

  task automatic sample_outputs();
    if (req_credit_o) begin
      req_credits++;
      if (req_credits > credits_lp) begin
        $display("decode returned more request credits than were spent");
        stop_on_error();
      end
    end
    // memory is always ready, so a request is taken in the cycle it shows up
    if (mem_req_v_o && mem_req_ready_i) begin
      if (mem_req_we_o) begin
        mem_model[mem_req_addr_o] = mem_req_data_o;
      end else if (rd_pending) begin
        $display("a second memory read started while one was still open");
        stop_on_error();
      end else begin
        rd_pending   = 1'b1;
        rd_countdown = 1 + int'($urandom % 32'd4);
        rd_data      = mem_read(mem_req_addr_o);
      end
    end
    if (resp_v_o) begin
      if (exp_id_q.size() == 0) begin
        $display("a response with id %h came with no request outstanding", resp_id_o);
        stop_on_error();
      end
      check_value("resp_id_o", 32'(resp_id_o), 32'(exp_id_q.pop_front()));
      check_value("resp_data_o", 32'(resp_data_o), 32'(exp_data_q.pop_front()));
      check_value("resp_hit_o", 32'(resp_hit_o), 32'(exp_hit_q.pop_front()));
      check_value("resp_status_o", 32'(resp_status_o), 32'(exp_stat_q.pop_front()));
      credit_due_q.push_back(cycle_count + 1 + exp_delay_q.pop_front());
      resp_count++;
    end
  endtask

  task automatic run_cycle();
    @(negedge clk_i);
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles with %0d of %0d responses seen",
               cycle_count, resp_count, num_lines);
      stop_on_error();
    end
    drive_memory();
    drive_resp_credit();
    drive_request();
    // let the combinational outputs settle before they are sampled
    #1;
    sample_outputs();
  endtask

  initial begin
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    req_v_i         = 1'b0;
    req_cmd_i       = tlc_pkg::CMD_LOAD;
    req_id_i        = '0;
    req_addr_i      = '0;
    req_data_i      = '0;
    resp_credit_i   = 1'b0;
    mem_req_ready_i = 1'b1;
    mem_resp_v_i    = 1'b0;
    mem_resp_data_i = '0;
    line_idx        = 0;
    resp_count      = 0;
    req_credits     = credits_lp;
    cycle_count     = 0;
    rd_pending      = 1'b0;
    rd_countdown    = 0;
    rd_data         = '0;
    void'($urandom(32'h4c52_4271));
    for (int s = 0; s < sets_lp; s++) begin
      model_rr[s] = 0;
      for (int w = 0; w < ways_lp; w++) begin
        model_valid[s][w] = 1'b0;
        model_tag[s][w]   = '0;
      end
    end

    $readmemh("test/tlc_stim.txt", stim_mem);
    num_lines = 0;
    while (num_lines < max_lines_lp && stim_mem[5*num_lines] != 16'h000f) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("the stimulus file holds no requests");
      stop_on_error();
    end
    cycle_limit = cycles_per_line_lp * num_lines;

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    while (resp_count < num_lines) begin
      run_cycle();
    end
    // a few quiet cycles catch any response that nobody asked for
    repeat (8) run_cycle();

    // once decode has drained, every request credit must be back with the requester
    if (req_credits != credits_lp) begin
      $display("only %0d of %0d request credits came back by the end of the run",
               req_credits, credits_lp);
      stop_on_error();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tlc_decode.sv ====
// request buffer of the cache front end
// circular buffer with request credit return, head entry goes to lookup
`timescale 1ns/1ns
`default_nettype none

module tlc_decode #(
  parameter int addr_width_p = 12,
  parameter int data_width_p = 16,
  parameter int id_width_p   = 4,
  parameter int credits_p    = 2
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    req_v_i,
  input  tlc_pkg::tlc_cmd_e            req_cmd_i,
  input  wire logic [id_width_p-1:0]   req_id_i,
  input  wire logic [addr_width_p-1:0] req_addr_i,
  input  wire logic [data_width_p-1:0] req_data_i,
  input  wire logic                    lk_ready_i,
  output logic                         req_credit_o,
  output logic                         dec_v_o,
  output tlc_pkg::tlc_cmd_e            dec_cmd_o,
  output logic [id_width_p-1:0]        dec_id_o,
  output logic [addr_width_p-1:0]      dec_addr_o,
  output logic [data_width_p-1:0]      dec_data_o
);

  localparam int ptr_width_lp = (credits_p > 1) ? $clog2(credits_p) : 1;
  localparam int cnt_width_lp = $clog2(credits_p + 1);

  tlc_pkg::tlc_cmd_e         cmd_q  [credits_p];
  logic [id_width_p-1:0]     id_q   [credits_p];
  logic [addr_width_p-1:0]   addr_q [credits_p];
  logic [data_width_p-1:0]   data_q [credits_p];
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [cnt_width_lp-1:0]   count_r;
  logic                      pop;

  assign dec_v_o    = (count_r != '0);
  assign pop        = dec_v_o & lk_ready_i;
  assign dec_cmd_o  = cmd_q[rd_ptr_r];
  assign dec_id_o   = id_q[rd_ptr_r];
  assign dec_addr_o = addr_q[rd_ptr_r];
  assign dec_data_o = data_q[rd_ptr_r];

  // one slot freed, one credit back to the requester
  assign req_credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (req_v_i) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(credits_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(credits_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({req_v_i, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // reserved codes are stored as they come, lookup flags them
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      cmd_q[wr_ptr_r]  <= req_cmd_i;
      id_q[wr_ptr_r]   <= req_id_i;
      addr_q[wr_ptr_r] <= req_addr_i;
      data_q[wr_ptr_r] <= req_data_i;
    end
  end

  // a request into a full buffer means the requester overdrew its credits
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i |-> (count_r != cnt_width_lp'(credits_p)));

endmodule

`default_nettype wire

// ==== verilog/tlc_miss_handler.sv ====
// miss handler for the tag-lookup stage
// memory read and write sequencing and round-robin victim choice per set
`timescale 1ns/1ns
`default_nettype none

module tlc_miss_handler #(
  parameter int addr_width_p = 12,
  parameter int data_width_p = 16,
  parameter int ways_p       = 2,
  parameter int sets_p       = 4,
  parameter int lg_ways_lp   = (ways_p > 1) ? $clog2(ways_p) : 1,
  parameter int lg_sets_lp   = (sets_p > 1) ? $clog2(sets_p) : 1
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    miss_v_i,
  input  wire logic                    miss_we_i,
  input  wire logic [addr_width_p-1:0] miss_addr_i,
  input  wire logic [data_width_p-1:0] miss_data_i,
  input  wire logic [lg_sets_lp-1:0]   miss_index_i,
  input  wire logic                    mem_req_ready_i,
  input  wire logic                    mem_resp_v_i,
  input  wire logic [data_width_p-1:0] mem_resp_data_i,
  output logic                         miss_done_o,
  output logic                         fill_v_o,
  output logic [lg_ways_lp-1:0]        fill_way_o,
  output logic [data_width_p-1:0]      fill_data_o,
  output logic                         mem_req_v_o,
  output logic                         mem_req_we_o,
  output logic [addr_width_p-1:0]      mem_req_addr_o,
  output logic [data_width_p-1:0]      mem_req_data_o
);

  tlc_pkg::tlc_miss_state_e state_r;
  tlc_pkg::tlc_miss_state_e state_n;
  logic [lg_ways_lp-1:0]    rr_r [sets_p];

  // the lookup stage holds the miss fields steady until miss_done
  assign mem_req_v_o    = (state_r == tlc_pkg::MS_READ) | (state_r == tlc_pkg::MS_WRITE);
  assign mem_req_we_o   = (state_r == tlc_pkg::MS_WRITE);
  assign mem_req_addr_o = miss_addr_i;
  assign mem_req_data_o = miss_data_i;

  assign fill_v_o    = (state_r == tlc_pkg::MS_WAIT) & mem_resp_v_i;
  assign fill_way_o  = rr_r[miss_index_i];
  assign fill_data_o = mem_resp_data_i;
  assign miss_done_o = fill_v_o | ((state_r == tlc_pkg::MS_WRITE) & mem_req_ready_i);

  always_comb begin
    state_n = state_r;
    case (state_r)
      tlc_pkg::MS_IDLE: begin
        if (miss_v_i) begin
          state_n = miss_we_i ? tlc_pkg::MS_WRITE : tlc_pkg::MS_READ;
        end
      end
      tlc_pkg::MS_READ:  if (mem_req_ready_i) state_n = tlc_pkg::MS_WAIT;
      tlc_pkg::MS_WAIT:  if (mem_resp_v_i) state_n = tlc_pkg::MS_IDLE;
      tlc_pkg::MS_WRITE: if (mem_req_ready_i) state_n = tlc_pkg::MS_IDLE;
      default:           state_n = tlc_pkg::MS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= tlc_pkg::MS_IDLE;
      for (int s = 0; s < sets_p; s++) begin
        rr_r[s] <= '0;
      end
    end else begin
      state_r <= state_n;
      // the pointer moves past the way that was just filled
      if (fill_v_o) begin
        rr_r[miss_index_i] <= (fill_way_o == lg_ways_lp'(ways_p - 1)) ? '0 : fill_way_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tlc_pkg.sv ====
// shared definitions for the tag-lookup cache
// command, status and miss-handler state encodings, plus default widths
`default_nettype none

package tlc_pkg;

  // incoming command codes, code 3 is reserved and answered with an error
  typedef enum logic [1:0] {
    CMD_LOAD  = 2'd0,
    CMD_STORE = 2'd1,
    CMD_INVAL = 2'd2,
    CMD_RSVD  = 2'd3
  } tlc_cmd_e;

  typedef enum logic {
    STAT_OK  = 1'b0,
    STAT_ERR = 1'b1
  } tlc_status_e;

  typedef enum logic [1:0] {
    MS_IDLE  = 2'd0,
    MS_READ  = 2'd1,
    MS_WAIT  = 2'd2,
    MS_WRITE = 2'd3
  } tlc_miss_state_e;

  localparam int ADDR_WIDTH = 12;
  localparam int DATA_WIDTH = 16;
  localparam int ID_WIDTH   = 4;
  localparam int WAYS       = 2;
  localparam int SETS       = 4;
  localparam int CREDITS    = 2;

endpackage

`default_nettype wire

// ==== verilog/tlc_result.sv ====
// result stage of the cache
// one-entry response register and the response credit counter
`timescale 1ns/1ns
`default_nettype none

module tlc_result #(
  parameter int data_width_p = 16,
  parameter int id_width_p   = 4,
  parameter int credits_p    = 2
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    res_v_i,
  input  wire logic [id_width_p-1:0]   res_id_i,
  input  wire logic [data_width_p-1:0] res_data_i,
  input  wire logic                    res_hit_i,
  input  tlc_pkg::tlc_status_e         res_status_i,
  input  wire logic                    resp_credit_i,
  output logic                         res_ready_o,
  output logic                         resp_v_o,
  output logic [id_width_p-1:0]        resp_id_o,
  output logic [data_width_p-1:0]      resp_data_o,
  output logic                         resp_hit_o,
  output tlc_pkg::tlc_status_e         resp_status_o
);

  localparam int cnt_width_lp = $clog2(credits_p + 1);

  logic                    full_r;
  logic [cnt_width_lp-1:0] credit_r;

  // the held response leaves as soon as a response slot is free
  assign resp_v_o = full_r & (credit_r != '0);

  // the register also counts as free in the cycle its response goes out
  assign res_ready_o = ~full_r | resp_v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r   <= 1'b0;
      credit_r <= cnt_width_lp'(credits_p);
    end else begin
      full_r   <= res_v_i | (full_r & ~resp_v_o);
      credit_r <= credit_r + cnt_width_lp'(resp_credit_i) - cnt_width_lp'(resp_v_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_v_i) begin
      resp_id_o     <= res_id_i;
      resp_data_o   <= res_data_i;
      resp_hit_o    <= res_hit_i;
      resp_status_o <= res_status_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    credit_r <= cnt_width_lp'(credits_p));

endmodule

`default_nettype wire

// ==== verilog/tlc_tag_lookup.sv ====
// tag-lookup stage with the tag, valid and data stores
// hit detection, stall control, store hit update and set invalidate
`timescale 1ns/1ns
`default_nettype none

module tlc_tag_lookup #(
  parameter int addr_width_p = 12,
  parameter int data_width_p = 16,
  parameter int id_width_p   = 4,
  parameter int ways_p       = 2,
  parameter int sets_p       = 4
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    dec_v_i,
  input  tlc_pkg::tlc_cmd_e            dec_cmd_i,
  input  wire logic [id_width_p-1:0]   dec_id_i,
  input  wire logic [addr_width_p-1:0] dec_addr_i,
  input  wire logic [data_width_p-1:0] dec_data_i,
  input  wire logic                    res_ready_i,
  input  wire logic                    mem_req_ready_i,
  input  wire logic                    mem_resp_v_i,
  input  wire logic [data_width_p-1:0] mem_resp_data_i,
  output logic                         lk_ready_o,
  output logic                         mem_req_v_o,
  output logic                         mem_req_we_o,
  output logic [addr_width_p-1:0]      mem_req_addr_o,
  output logic [data_width_p-1:0]      mem_req_data_o,
  output logic                         res_v_o,
  output logic [id_width_p-1:0]        res_id_o,
  output logic [data_width_p-1:0]      res_data_o,
  output logic                         res_hit_o,
  output tlc_pkg::tlc_status_e         res_status_o
);

  localparam int lg_sets_lp   = (sets_p > 1) ? $clog2(sets_p) : 1;
  localparam int lg_ways_lp   = (ways_p > 1) ? $clog2(ways_p) : 1;
  localparam int tag_width_lp = addr_width_p - lg_sets_lp;

  logic [ways_p-1:0]       valid_mem [sets_p];
  logic [tag_width_lp-1:0] tag_mem   [sets_p][ways_p];
  logic [data_width_p-1:0] data_mem  [sets_p][ways_p];

  // the entry being looked up
  logic                    v_r;
  tlc_pkg::tlc_cmd_e       cmd_r;
  logic [id_width_p-1:0]   id_r;
  logic [addr_width_p-1:0] addr_r;
  logic [data_width_p-1:0] wdata_r;
  logic                    mem_done_r;

  logic [lg_sets_lp-1:0]   index;
  logic [tag_width_lp-1:0] tag;
  logic [ways_p-1:0]       hit_vec;
  logic                    hit;
  logic [lg_ways_lp-1:0]   hit_way;
  logic                    is_load;
  logic                    is_store;
  logic                    need_mem;
  logic                    mem_ok;
  logic                    miss_v;
  logic                    miss_done;
  logic                    fill_v;
  logic [lg_ways_lp-1:0]   fill_way;
  logic [data_width_p-1:0] fill_data;

  assign index    = addr_r[lg_sets_lp-1:0];
  assign tag      = addr_r[addr_width_p-1:lg_sets_lp];
  assign is_load  = (cmd_r == tlc_pkg::CMD_LOAD);
  assign is_store = (cmd_r == tlc_pkg::CMD_STORE);

  // scanning from the top down leaves the lowest matching way in hit_way
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = ways_p - 1; w >= 0; w--) begin
      hit_vec[w] = valid_mem[index][w] & (tag_mem[index][w] == tag);
      if (hit_vec[w]) begin
        hit     = 1'b1;
        hit_way = lg_ways_lp'(w);
      end
    end
  end

  // stores always go to memory, loads only on a miss
  assign need_mem = is_store | (is_load & ~hit);
  assign miss_v   = v_r & need_mem & ~mem_done_r;
  assign mem_ok   = ~need_mem | mem_done_r | miss_done;

  assign res_v_o    = v_r & mem_ok & res_ready_i;
  assign lk_ready_o = dec_v_i & (~v_r | res_v_o);
  assign res_id_o   = id_r;

  assign res_status_o = (cmd_r == tlc_pkg::CMD_RSVD) ? tlc_pkg::STAT_ERR : tlc_pkg::STAT_OK;

  // after a fill the load hits on its own data, so the miss is remembered
  assign res_hit_o = hit & (is_store | (is_load & ~mem_done_r));

  always_comb begin
    case (cmd_r)
      tlc_pkg::CMD_LOAD:  res_data_o = miss_done ? fill_data : data_mem[index][hit_way];
      tlc_pkg::CMD_STORE: res_data_o = wdata_r;
      default:            res_data_o = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r        <= 1'b0;
      mem_done_r <= 1'b0;
      for (int s = 0; s < sets_p; s++) begin
        valid_mem[s] <= '0;
      end
    end else begin
      v_r        <= lk_ready_o | (v_r & ~res_v_o);
      mem_done_r <= ~res_v_o & (mem_done_r | miss_done);
      if (fill_v) begin
        valid_mem[index][fill_way] <= 1'b1;
      end
      if (res_v_o && cmd_r == tlc_pkg::CMD_INVAL) begin
        valid_mem[index] <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lk_ready_o) begin
      cmd_r   <= dec_cmd_i;
      id_r    <= dec_id_i;
      addr_r  <= dec_addr_i;
      wdata_r <= dec_data_i;
    end
    if (fill_v) begin
      tag_mem[index][fill_way]  <= tag;
      data_mem[index][fill_way] <= fill_data;
    end
    if (res_v_o & is_store & hit) begin
      data_mem[index][hit_way] <= wdata_r;
    end
  end

  tlc_miss_handler #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p),
    .ways_p      (ways_p),
    .sets_p      (sets_p)
  ) u_miss_handler (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .miss_v_i       (miss_v),
    .miss_we_i      (is_store),
    .miss_addr_i    (addr_r),
    .miss_data_i    (wdata_r),
    .miss_index_i   (index),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_resp_v_i   (mem_resp_v_i),
    .mem_resp_data_i(mem_resp_data_i),
    .miss_done_o    (miss_done),
    .fill_v_o       (fill_v),
    .fill_way_o     (fill_way),
    .fill_data_o    (fill_data),
    .mem_req_v_o    (mem_req_v_o),
    .mem_req_we_o   (mem_req_we_o),
    .mem_req_addr_o (mem_req_addr_o),
    .mem_req_data_o (mem_req_data_o)
  );

  // a new entry only enters once the handler has gone back to idle
  assert property (@(posedge clk_i) disable iff (reset_i)
    lk_ready_o |=> (u_miss_handler.state_r == tlc_pkg::MS_IDLE));

  // fills only go in on a miss, so a tag can never sit in two ways
  assert property (@(posedge clk_i) disable iff (reset_i)
    v_r |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

// ==== verilog/tlc_top.sv ====
// top level of the tag-lookup cache
// decode, lookup and result stages wired to the requester and memory ports
`timescale 1ns/1ns
`default_nettype none

module tlc_top #(
  parameter int addr_width_p = tlc_pkg::ADDR_WIDTH,
  parameter int data_width_p = tlc_pkg::DATA_WIDTH,
  parameter int id_width_p   = tlc_pkg::ID_WIDTH,
  parameter int ways_p       = tlc_pkg::WAYS,
  parameter int sets_p       = tlc_pkg::SETS,
  parameter int credits_p    = tlc_pkg::CREDITS
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,
  input  wire logic                    req_v_i,
  input  tlc_pkg::tlc_cmd_e            req_cmd_i,
  input  wire logic [id_width_p-1:0]   req_id_i,
  input  wire logic [addr_width_p-1:0] req_addr_i,
  input  wire logic [data_width_p-1:0] req_data_i,
  output logic                         req_credit_o,
  output logic                         resp_v_o,
  output logic [id_width_p-1:0]        resp_id_o,
  output logic [data_width_p-1:0]      resp_data_o,
  output logic                         resp_hit_o,
  output tlc_pkg::tlc_status_e         resp_status_o,
  input  wire logic                    resp_credit_i,
  output logic                         mem_req_v_o,
  output logic                         mem_req_we_o,
  output logic [addr_width_p-1:0]      mem_req_addr_o,
  output logic [data_width_p-1:0]      mem_req_data_o,
  input  wire logic                    mem_req_ready_i,
  input  wire logic                    mem_resp_v_i,
  input  wire logic [data_width_p-1:0] mem_resp_data_i
);

  logic                    dec_v;
  tlc_pkg::tlc_cmd_e       dec_cmd;
  logic [id_width_p-1:0]   dec_id;
  logic [addr_width_p-1:0] dec_addr;
  logic [data_width_p-1:0] dec_data;
  logic                    lk_ready;
  logic                    res_v;
  logic                    res_ready;
  logic [id_width_p-1:0]   res_id;
  logic [data_width_p-1:0] res_data;
  logic                    res_hit;
  tlc_pkg::tlc_status_e    res_status;

  tlc_decode #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p),
    .id_width_p  (id_width_p),
    .credits_p   (credits_p)
  ) u_decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v_i),
    .req_cmd_i   (req_cmd_i),
    .req_id_i    (req_id_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .lk_ready_i  (lk_ready),
    .req_credit_o(req_credit_o),
    .dec_v_o     (dec_v),
    .dec_cmd_o   (dec_cmd),
    .dec_id_o    (dec_id),
    .dec_addr_o  (dec_addr),
    .dec_data_o  (dec_data)
  );

  tlc_tag_lookup #(
    .addr_width_p(addr_width_p),
    .data_width_p(data_width_p),
    .id_width_p  (id_width_p),
    .ways_p      (ways_p),
    .sets_p      (sets_p)
  ) u_tag_lookup (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .dec_v_i        (dec_v),
    .dec_cmd_i      (dec_cmd),
    .dec_id_i       (dec_id),
    .dec_addr_i     (dec_addr),
    .dec_data_i     (dec_data),
    .res_ready_i    (res_ready),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_resp_v_i   (mem_resp_v_i),
    .mem_resp_data_i(mem_resp_data_i),
    .lk_ready_o     (lk_ready),
    .mem_req_v_o    (mem_req_v_o),
    .mem_req_we_o   (mem_req_we_o),
    .mem_req_addr_o (mem_req_addr_o),
    .mem_req_data_o (mem_req_data_o),
    .res_v_o        (res_v),
    .res_id_o       (res_id),
    .res_data_o     (res_data),
    .res_hit_o      (res_hit),
    .res_status_o   (res_status)
  );

  tlc_result #(
    .data_width_p(data_width_p),
    .id_width_p  (id_width_p),
    .credits_p   (credits_p)
  ) u_result (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .res_v_i      (res_v),
    .res_id_i     (res_id),
    .res_data_i   (res_data),
    .res_hit_i    (res_hit),
    .res_status_i (res_status),
    .resp_credit_i(resp_credit_i),
    .res_ready_o  (res_ready),
    .resp_v_o     (resp_v_o),
    .resp_id_o    (resp_id_o),
    .resp_data_o  (resp_data_o),
    .resp_hit_o   (resp_hit_o),
    .resp_status_o(resp_status_o)
  );

endmodule

`default_nettype wire
